//--- design/decode_pkg.sv
package decode_pkg;

    //////////////////////////////
    // Basic types
    //////////////////////////////

    typedef logic [31:0] instr_t;
    typedef logic [4:0]  reg_addr_t;

    // Field view of a 32-bit word, R-type layout
    typedef struct packed {
        logic [6:0] funct7;
        reg_addr_t  rs2;
        reg_addr_t  rs1;
        logic [2:0] funct3;
        reg_addr_t  rd;
        logic [6:0] opcode;
    } instr_fields_t;

    //////////////////////////////
    // Opcodes and fields
    //////////////////////////////

    localparam logic [6:0] OPCODE_OP     = 7'b0110011;
    localparam logic [6:0] OPCODE_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPCODE_LUI    = 7'b0110111;
    localparam logic [6:0] OPCODE_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPCODE_LOAD   = 7'b0000011;
    localparam logic [6:0] OPCODE_STORE  = 7'b0100011;
    localparam logic [6:0] OPCODE_BRANCH = 7'b1100011;
    localparam logic [6:0] OPCODE_JAL    = 7'b1101111;
    localparam logic [6:0] OPCODE_JALR   = 7'b1100111;
    localparam logic [6:0] OPCODE_SYSTEM = 7'b1110011;

    localparam logic [6:0] FUNCT7_BASE = 7'h00;
    localparam logic [6:0] FUNCT7_ALT  = 7'h20; // SUB, SRA and SRAI

    // Machine CSRs known to the core
    localparam logic [11:0] CSR_MISA      = 12'h301;
    localparam logic [11:0] CSR_MVENDORID = 12'hF11; // Read only
    localparam logic [11:0] CSR_MARCHID   = 12'hF12; // Read only
    localparam logic [11:0] CSR_MIMPID    = 12'hF13; // Read only
    localparam logic [11:0] CSR_MHARTID   = 12'hF14; // Read only

    //////////////////////////////
    // Control word
    //////////////////////////////

    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,  ALU_SUB  = 4'd1,  ALU_XOR = 4'd2,  ALU_OR  = 4'd3,
        ALU_AND  = 4'd4,  ALU_SLL  = 4'd5,  ALU_SRL = 4'd6,  ALU_SRA = 4'd7,
        ALU_SLT  = 4'd8,  ALU_SLTU = 4'd9,  ALU_SEQ = 4'd10, ALU_SNE = 4'd11,
        ALU_SGE  = 4'd12, ALU_SGEU = 4'd13
    } alu_op_t;

    typedef enum logic [1:0] {SRC1_RS1, SRC1_PC, SRC1_ZERO, SRC1_IMM_CSR} alu_src1_t;
    typedef enum logic [1:0] {SRC2_RS2, SRC2_IMM, SRC2_FOUR} alu_src2_t;
    typedef enum logic [2:0] {IMM_I, IMM_S, IMM_B, IMM_U, IMM_J} imm_type_t;
    typedef enum logic [1:0] {MEM_BYTE, MEM_HALF, MEM_WORD} mem_size_t;
    typedef enum logic [1:0] {PC_PLUS4, PC_BRANCH, PC_JAL, PC_JALR} pc_src_t;
    typedef enum logic [1:0] {CSR_READ, CSR_WRITE, CSR_SET, CSR_CLEAR} csr_op_t;

    typedef struct packed {
        alu_op_t   alu_op;
        alu_src1_t src1;
        alu_src2_t src2;
        imm_type_t imm_type;
        reg_addr_t rs1;
        reg_addr_t rs2;
        reg_addr_t rd;
        logic      mem_wen;
        mem_size_t mem_size;
        logic      mem_sign;     // Sign-extend load data
        logic      reg_alu_wen;
        logic      reg_mem_wen;
        pc_src_t   pc_src;
        logic      is_branch;
        logic      csr_access;
        csr_op_t   csr_op;
        logic      illegal;
    } ctrl_t;

    // Base for every class decoder, a harmless no-op
    localparam ctrl_t CTRL_DEFAULT = '{
        alu_op:      ALU_ADD,
        src1:        SRC1_RS1,
        src2:        SRC2_RS2,
        imm_type:    IMM_I,
        rs1:         '0,
        rs2:         '0,
        rd:          '0,
        mem_wen:     1'b0,
        mem_size:    MEM_WORD,
        mem_sign:    1'b0,
        reg_alu_wen: 1'b0,
        reg_mem_wen: 1'b0,
        pc_src:      PC_PLUS4,
        is_branch:   1'b0,
        csr_access:  1'b0,
        csr_op:      CSR_READ,
        illegal:     1'b0
    };

endpackage

//--- design/pipe_stage.sv
module pipe_stage #(
    parameter type payload_t = logic [31:0]
) (
    input  logic     clk_i,
    input  logic     rst_n_i,

    // Upstream side
    input  logic     valid_i,
    output logic     ready_o,
    input  payload_t data_i,

    // Downstream side
    output logic     valid_o,
    input  logic     ready_i,
    output payload_t data_o
);

    logic     valid_q;
    payload_t data_q;

    // Free slot, or the held item leaves this cycle
    assign ready_o = !valid_q || ready_i;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            valid_q <= 1'b0;
        end else if (ready_o) begin
            valid_q <= valid_i;
        end
    end

    // Payload only moves on an accepted transfer
    always_ff @(posedge clk_i) begin
        if (valid_i && ready_o) begin
            data_q <= data_i;
        end
    end

    assign valid_o = valid_q;
    assign data_o  = data_q;

endmodule

//--- design/alu_decoder.sv
module alu_decoder (
    input  decode_pkg::instr_t instr_i,
    output logic               hit_o,
    output decode_pkg::ctrl_t  ctrl_o
);
    import decode_pkg::*;

    instr_fields_t fld;

    assign fld = instr_i;

    always_comb begin
        hit_o  = 1'b0;
        ctrl_o = CTRL_DEFAULT;

        case (fld.opcode)
            //////////////////////////////
            // Register-register
            //////////////////////////////
            OPCODE_OP: begin
                hit_o              = 1'b1;
                ctrl_o.reg_alu_wen = 1'b1;
                if (fld.funct7 == FUNCT7_BASE) begin
                    unique case (fld.funct3)
                        3'b000: ctrl_o.alu_op = ALU_ADD;
                        3'b001: ctrl_o.alu_op = ALU_SLL;
                        3'b010: ctrl_o.alu_op = ALU_SLT;
                        3'b011: ctrl_o.alu_op = ALU_SLTU;
                        3'b100: ctrl_o.alu_op = ALU_XOR;
                        3'b101: ctrl_o.alu_op = ALU_SRL;
                        3'b110: ctrl_o.alu_op = ALU_OR;
                        3'b111: ctrl_o.alu_op = ALU_AND;
                    endcase
                end else if (fld.funct7 == FUNCT7_ALT) begin
                    case (fld.funct3)
                        3'b000:  ctrl_o.alu_op  = ALU_SUB;
                        3'b101:  ctrl_o.alu_op  = ALU_SRA;
                        default: ctrl_o.illegal = 1'b1;
                    endcase
                end else begin
                    ctrl_o.illegal = 1'b1; // M extension not supported
                end
            end

            //////////////////////////////
            // Register-immediate
            //////////////////////////////
            OPCODE_OP_IMM: begin
                hit_o              = 1'b1;
                ctrl_o.src2        = SRC2_IMM;
                ctrl_o.reg_alu_wen = 1'b1;
                unique case (fld.funct3)
                    3'b000: ctrl_o.alu_op = ALU_ADD;
                    3'b010: ctrl_o.alu_op = ALU_SLT;
                    3'b011: ctrl_o.alu_op = ALU_SLTU;
                    3'b100: ctrl_o.alu_op = ALU_XOR;
                    3'b110: ctrl_o.alu_op = ALU_OR;
                    3'b111: ctrl_o.alu_op = ALU_AND;
                    3'b001: begin
                        ctrl_o.alu_op  = ALU_SLL;
                        ctrl_o.illegal = (fld.funct7 != FUNCT7_BASE);
                    end
                    3'b101: begin
                        // Upper bits pick logical or arithmetic shift
                        ctrl_o.alu_op  = (fld.funct7 == FUNCT7_ALT) ? ALU_SRA : ALU_SRL;
                        ctrl_o.illegal = !(fld.funct7 inside {FUNCT7_BASE, FUNCT7_ALT});
                    end
                endcase
            end

            OPCODE_LUI, OPCODE_AUIPC: begin
                hit_o              = 1'b1;
                ctrl_o.src1        = (fld.opcode == OPCODE_LUI) ? SRC1_ZERO : SRC1_PC;
                ctrl_o.src2        = SRC2_IMM;
                ctrl_o.imm_type    = IMM_U;
                ctrl_o.reg_alu_wen = 1'b1;
            end

            default: ;
        endcase
    end

endmodule

//--- design/mem_decoder.sv
module mem_decoder (
    input  decode_pkg::instr_t instr_i,
    output logic               hit_o,
    output decode_pkg::ctrl_t  ctrl_o
);
    import decode_pkg::*;

    instr_fields_t fld;

    assign fld = instr_i;

    always_comb begin
        hit_o  = 1'b0;
        ctrl_o = CTRL_DEFAULT;

        // Address is always rs1 plus immediate
        if (fld.opcode inside {OPCODE_LOAD, OPCODE_STORE}) begin
            hit_o         = 1'b1;
            ctrl_o.alu_op = ALU_ADD;
            ctrl_o.src2   = SRC2_IMM;
        end

        if (fld.opcode == OPCODE_LOAD) begin
            ctrl_o.imm_type    = IMM_I;
            ctrl_o.reg_mem_wen = 1'b1;
            ctrl_o.mem_sign    = !fld.funct3[2]; // lbu and lhu zero-extend
            case (fld.funct3)
                3'b000, 3'b100: ctrl_o.mem_size = MEM_BYTE;
                3'b001, 3'b101: ctrl_o.mem_size = MEM_HALF;
                3'b010:         ctrl_o.mem_size = MEM_WORD;
                default:        ctrl_o.illegal  = 1'b1;
            endcase
        end else if (fld.opcode == OPCODE_STORE) begin
            ctrl_o.imm_type = IMM_S;
            ctrl_o.mem_wen  = 1'b1;
            case (fld.funct3)
                3'b000:  ctrl_o.mem_size = MEM_BYTE;
                3'b001:  ctrl_o.mem_size = MEM_HALF;
                3'b010:  ctrl_o.mem_size = MEM_WORD;
                default: ctrl_o.illegal  = 1'b1;
            endcase
        end
    end

endmodule

//--- design/flow_decoder.sv
module flow_decoder (
    input  decode_pkg::instr_t instr_i,
    output logic               hit_o,
    output decode_pkg::ctrl_t  ctrl_o
);
    import decode_pkg::*;

    instr_fields_t fld;

    assign fld = instr_i;

    always_comb begin
        hit_o  = 1'b0;
        ctrl_o = CTRL_DEFAULT;

        case (fld.opcode)
            // ALU compares rs1 and rs2, target has its own adder
            OPCODE_BRANCH: begin
                hit_o            = 1'b1;
                ctrl_o.imm_type  = IMM_B;
                ctrl_o.pc_src    = PC_BRANCH;
                ctrl_o.is_branch = 1'b1;
                case (fld.funct3)
                    3'b000:  ctrl_o.alu_op  = ALU_SEQ;
                    3'b001:  ctrl_o.alu_op  = ALU_SNE;
                    3'b100:  ctrl_o.alu_op  = ALU_SLT;
                    3'b101:  ctrl_o.alu_op  = ALU_SGE;
                    3'b110:  ctrl_o.alu_op  = ALU_SLTU;
                    3'b111:  ctrl_o.alu_op  = ALU_SGEU;
                    default: ctrl_o.illegal = 1'b1;
                endcase
            end

            // Link value is PC plus four
            OPCODE_JAL, OPCODE_JALR: begin
                hit_o              = 1'b1;
                ctrl_o.alu_op      = ALU_ADD;
                ctrl_o.src1        = SRC1_PC;
                ctrl_o.src2        = SRC2_FOUR;
                ctrl_o.reg_alu_wen = 1'b1;
                if (fld.opcode == OPCODE_JAL) begin
                    ctrl_o.imm_type = IMM_J;
                    ctrl_o.pc_src   = PC_JAL;
                end else begin
                    ctrl_o.imm_type = IMM_I;
                    ctrl_o.pc_src   = PC_JALR;
                    ctrl_o.illegal  = (fld.funct3 != 3'b000);
                end
            end

            default: ;
        endcase
    end

endmodule

//--- design/csr_decoder.sv
module csr_decoder (
    input  decode_pkg::instr_t instr_i,
    output logic               hit_o,
    output decode_pkg::ctrl_t  ctrl_o
);
    import decode_pkg::*;

    instr_fields_t fld;
    logic [11:0]   csr_addr;
    csr_op_t       set_clr_op;  // SET or CLEAR, READ when rs1 field is zero

    assign fld      = instr_i;
    assign csr_addr = instr_i[31:20];

    always_comb begin
        set_clr_op = fld.funct3[0] ? CSR_CLEAR : CSR_SET;
        if (fld.rs1 == '0) begin
            set_clr_op = CSR_READ;
        end
    end

    always_comb begin
        hit_o  = (fld.opcode == OPCODE_SYSTEM);
        ctrl_o = CTRL_DEFAULT;

        if (hit_o) begin
            if (fld.rs1 == '0 && fld.rd == '0) begin
                ctrl_o.illegal = 1'b1; // ECALL, EBREAK and friends
            end else begin
                ctrl_o.csr_access  = 1'b1;
                ctrl_o.reg_alu_wen = 1'b1;
                ctrl_o.src2        = SRC2_IMM;
                if (fld.funct3[2]) begin
                    ctrl_o.src1 = SRC1_IMM_CSR; // uimm in the rs1 field
                end
                case (fld.funct3[1:0])
                    2'b01:   ctrl_o.csr_op  = CSR_WRITE;
                    2'b10,
                    2'b11:   ctrl_o.csr_op  = set_clr_op;
                    default: ctrl_o.illegal = 1'b1;
                endcase

                // Only misa is writable
                case (csr_addr)
                    CSR_MISA: ;
                    CSR_MVENDORID, CSR_MARCHID, CSR_MIMPID, CSR_MHARTID: begin
                        if (ctrl_o.csr_op != CSR_READ) ctrl_o.illegal = 1'b1;
                    end
                    default: ctrl_o.illegal = 1'b1;
                endcase
            end
        end
    end

endmodule

//--- design/instr_decoder.sv
module instr_decoder (
    input  decode_pkg::instr_t instr_i,
    output decode_pkg::ctrl_t  ctrl_o
);
    import decode_pkg::*;

    instr_fields_t fld;
    logic          alu_hit, mem_hit, flow_hit, csr_hit;
    ctrl_t         alu_ctrl, mem_ctrl, flow_ctrl, csr_ctrl;

    assign fld = instr_i;

    alu_decoder  i_alu_decoder  (.instr_i(instr_i), .hit_o(alu_hit),  .ctrl_o(alu_ctrl));
    mem_decoder  i_mem_decoder  (.instr_i(instr_i), .hit_o(mem_hit),  .ctrl_o(mem_ctrl));
    flow_decoder i_flow_decoder (.instr_i(instr_i), .hit_o(flow_hit), .ctrl_o(flow_ctrl));
    csr_decoder  i_csr_decoder  (.instr_i(instr_i), .hit_o(csr_hit),  .ctrl_o(csr_ctrl));

    always_comb begin
        // Opcode claimed by no class
        ctrl_o         = CTRL_DEFAULT;
        ctrl_o.illegal = 1'b1;

        // Classes own disjoint opcodes, at most one hit
        if (alu_hit) begin
            ctrl_o = alu_ctrl;
        end else if (mem_hit) begin
            ctrl_o = mem_ctrl;
        end else if (flow_hit) begin
            ctrl_o = flow_ctrl;
        end else if (csr_hit) begin
            ctrl_o = csr_ctrl;
        end

        // Register addresses straight from the fixed fields
        ctrl_o.rs1 = fld.rs1;
        ctrl_o.rs2 = fld.rs2;
        ctrl_o.rd  = fld.rd;
    end

endmodule

//--- design/decode_stage.sv
module decode_stage (
    input  logic               clk_i,
    input  logic               rst_n_i,

    // Instruction stream in
    input  logic               in_valid_i,
    output logic               in_ready_o,
    input  decode_pkg::instr_t in_instr_i,

    // Control word stream out
    output logic               out_valid_o,
    input  logic               out_ready_i,
    output decode_pkg::ctrl_t  out_ctrl_o
);
    import decode_pkg::*;

    logic   id_valid;
    logic   id_ready;
    instr_t id_instr;
    ctrl_t  id_ctrl;   // Decoded, not yet registered

    pipe_stage #(.payload_t(instr_t)) i_instr_reg (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .valid_i (in_valid_i),
        .ready_o (in_ready_o),
        .data_i  (in_instr_i),
        .valid_o (id_valid),
        .ready_i (id_ready),
        .data_o  (id_instr)
    );

    instr_decoder i_instr_decoder (.instr_i(id_instr), .ctrl_o(id_ctrl));

    pipe_stage #(.payload_t(ctrl_t)) i_ctrl_reg (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .valid_i (id_valid),
        .ready_o (id_ready),
        .data_i  (id_ctrl),
        .valid_o (out_valid_o),
        .ready_i (out_ready_i),
        .data_o  (out_ctrl_o)
    );

endmodule

//--- testbench/decode_stage_assert.sv
module handshake_assert #(
    parameter int data_width = 32
) (
    input logic                  clk_i,
    input logic                  rst_n_i,
    input logic                  valid_i,
    input logic                  ready_i,
    input logic [data_width-1:0] data_i
);

    // Held item stays put under back-pressure
    hold_valid: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        valid_i && !ready_i |=> valid_i)
        else $error("valid dropped before the item was taken");

    hold_data: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        valid_i && !ready_i |=> $stable(data_i))
        else $error("data changed while the item was waiting");

    reset_empty: assert property (@(posedge clk_i) !rst_n_i |=> !valid_i)
        else $error("valid high in the cycle after reset");   // Stage must come up empty

endmodule

bind pipe_stage handshake_assert #(.data_width($bits(data_o))) i_handshake_assert (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .valid_i (valid_o),
    .ready_i (ready_i),
    .data_i  (data_o)
);

//--- testbench/decode_stage_tb.sv
module decode_stage_tb;
    import decode_pkg::*;

    logic   clk_i = 1'b0;
    logic   rst_n_i;
    logic   in_valid_i;
    logic   in_ready_o;
    instr_t in_instr_i;
    logic   out_valid_o;
    logic   out_ready_i;
    ctrl_t  out_ctrl_o;

    // Test table with the same index in all three queues
    string  name_q[$];
    instr_t instr_q[$];
    ctrl_t  exp_q[$];

    integer seed;
    int     cycles;   // Timeout counter

    decode_stage i_decode_stage (.*);

    always #4 clk_i = ~clk_i;

    //////////////////////////////
    // Expected control words
    //////////////////////////////

    function automatic ctrl_t reg_exp(input alu_op_t op, input alu_src2_t src2);
        ctrl_t c = CTRL_DEFAULT;
        c.alu_op      = op;
        c.src2        = src2;
        c.reg_alu_wen = 1'b1;
        return c;
    endfunction

    // LUI and AUIPC
    function automatic ctrl_t upper_exp(input alu_src1_t src1);
        ctrl_t c = reg_exp(ALU_ADD, SRC2_IMM);
        c.src1     = src1;
        c.imm_type = IMM_U;
        return c;
    endfunction

    function automatic ctrl_t mem_exp(input mem_size_t size, input logic sign, input logic store);
        ctrl_t c = CTRL_DEFAULT;
        c.src2        = SRC2_IMM;
        c.imm_type    = store ? IMM_S : IMM_I;
        c.mem_wen     = store;
        c.reg_mem_wen = !store;
        c.mem_size    = size;
        c.mem_sign    = sign;
        return c;
    endfunction

    function automatic ctrl_t branch_exp(input alu_op_t op);
        ctrl_t c = CTRL_DEFAULT;
        c.alu_op    = op;
        c.imm_type  = IMM_B;
        c.pc_src    = PC_BRANCH;
        c.is_branch = 1'b1;
        return c;
    endfunction

    // Link value is PC plus four
    function automatic ctrl_t jump_exp(input pc_src_t pc_src, input imm_type_t imm);
        ctrl_t c = reg_exp(ALU_ADD, SRC2_FOUR);
        c.src1     = SRC1_PC;
        c.pc_src   = pc_src;
        c.imm_type = imm;
        return c;
    endfunction

    function automatic ctrl_t csr_exp(input csr_op_t op, input logic uimm);
        ctrl_t c = reg_exp(ALU_ADD, SRC2_IMM);
        c.csr_access = 1'b1;
        c.csr_op     = op;
        c.src1       = uimm ? SRC1_IMM_CSR : SRC1_RS1;
        return c;
    endfunction

    function automatic ctrl_t illegal_exp();
        ctrl_t c = CTRL_DEFAULT;
        c.illegal = 1'b1;
        return c;
    endfunction

    //////////////////////////////
    // Checks
    //////////////////////////////

    task automatic stop_with_failure(input string reason);
        $display("%s", reason);
        $display("Simulation finished: FAIL");
        $fatal(1, "Run stopped at first error");
    endtask

    task automatic check_ctrl(input string test, input ctrl_t exp, input ctrl_t act);
        if (act !== exp) begin
            stop_with_failure($sformatf("MISMATCH %s: expected %h, actual %h", test, exp, act));
        end
    endtask

    task automatic check_illegal(input string test, input logic exp, input logic act);
        if (act !== exp) begin
            stop_with_failure($sformatf("MISMATCH %s: expected illegal %b, actual %b",
                                        test, exp, act));
        end
    endtask

    task automatic check_handshake(input string test, input logic exp, input logic act);
        if (act !== exp) begin
            stop_with_failure($sformatf("MISMATCH %s: expected %b, actual %b", test, exp, act));
        end
    endtask

    // Register addresses are the fixed 32-bit fields
    task automatic add_test(input string test, input instr_t instr, input ctrl_t exp);
        ctrl_t c = exp;
        c.rs1 = instr[19:15];
        c.rs2 = instr[24:20];
        c.rd  = instr[11:7];
        name_q.push_back(test);
        instr_q.push_back(instr);
        exp_q.push_back(c);
    endtask

    task automatic build_table();
        add_test("add", {7'h00, 5'd2, 5'd1, 3'b000, 5'd3, OPCODE_OP}, reg_exp(ALU_ADD, SRC2_RS2));
        add_test("sub", {7'h20, 5'd6, 5'd5, 3'b000, 5'd4, OPCODE_OP}, reg_exp(ALU_SUB, SRC2_RS2));
        add_test("sra", {7'h20, 5'd8, 5'd7, 3'b101, 5'd9, OPCODE_OP}, reg_exp(ALU_SRA, SRC2_RS2));
        add_test("sltu", {7'h00, 5'd1, 5'd2, 3'b011, 5'd12, OPCODE_OP},
                 reg_exp(ALU_SLTU, SRC2_RS2));
        add_test("addi", {12'hFFB, 5'd2, 3'b000, 5'd1, OPCODE_OP_IMM}, reg_exp(ALU_ADD, SRC2_IMM));
        add_test("slli", {7'h00, 5'd3, 5'd6, 3'b001, 5'd5, OPCODE_OP_IMM},
                 reg_exp(ALU_SLL, SRC2_IMM));
        add_test("srai", {7'h20, 5'd4, 5'd8, 3'b101, 5'd7, OPCODE_OP_IMM},
                 reg_exp(ALU_SRA, SRC2_IMM));
        add_test("lui", {20'h12345, 5'd10, OPCODE_LUI}, upper_exp(SRC1_ZERO));
        add_test("auipc", {20'hABCDE, 5'd11, OPCODE_AUIPC}, upper_exp(SRC1_PC));
        // Loads and stores
        add_test("lb", {12'h004, 5'd2, 3'b000, 5'd1, OPCODE_LOAD}, mem_exp(MEM_BYTE, 1'b1, 1'b0));
        add_test("lhu", {12'h010, 5'd3, 3'b101, 5'd4, OPCODE_LOAD}, mem_exp(MEM_HALF, 1'b0, 1'b0));
        add_test("lw", {12'h7FC, 5'd5, 3'b010, 5'd6, OPCODE_LOAD}, mem_exp(MEM_WORD, 1'b1, 1'b0));
        add_test("sb", {7'h00, 5'd7, 5'd8, 3'b000, 5'd1, OPCODE_STORE},
                 mem_exp(MEM_BYTE, 1'b0, 1'b1));
        add_test("sw", {7'h7F, 5'd9, 5'd10, 3'b010, 5'd28, OPCODE_STORE},
                 mem_exp(MEM_WORD, 1'b0, 1'b1));
        // Control transfer
        add_test("beq", {7'h00, 5'd2, 5'd1, 3'b000, 5'd8, OPCODE_BRANCH}, branch_exp(ALU_SEQ));
        add_test("bgeu", {7'h7F, 5'd4, 5'd3, 3'b111, 5'd29, OPCODE_BRANCH}, branch_exp(ALU_SGEU));
        add_test("jal", {20'h00100, 5'd1, OPCODE_JAL}, jump_exp(PC_JAL, IMM_J));
        add_test("jalr", {12'h000, 5'd5, 3'b000, 5'd1, OPCODE_JALR}, jump_exp(PC_JALR, IMM_I));
        // CSR access
        add_test("csrrw_misa", {CSR_MISA, 5'd2, 3'b001, 5'd1, OPCODE_SYSTEM},
                 csr_exp(CSR_WRITE, 1'b0));
        add_test("csrrs_read", {CSR_MISA, 5'd0, 3'b010, 5'd3, OPCODE_SYSTEM},
                 csr_exp(CSR_READ, 1'b0));
        add_test("csrrci", {CSR_MISA, 5'd5, 3'b111, 5'd4, OPCODE_SYSTEM},
                 csr_exp(CSR_CLEAR, 1'b1));
        add_test("csrrs_mhartid", {CSR_MHARTID, 5'd0, 3'b010, 5'd5, OPCODE_SYSTEM},
                 csr_exp(CSR_READ, 1'b0));
        add_test("csrrw_mhartid", {CSR_MHARTID, 5'd6, 3'b001, 5'd7, OPCODE_SYSTEM}, illegal_exp());
        // Illegal encodings checked on the flag only
        add_test("bad_opcode", {25'd0, 7'h7F}, illegal_exp());
        add_test("op_funct7", {7'h01, 5'd2, 5'd1, 3'b000, 5'd3, OPCODE_OP}, illegal_exp());
        add_test("slli_funct7", {7'h20, 5'd1, 5'd2, 3'b001, 5'd3, OPCODE_OP_IMM}, illegal_exp());
        add_test("load_funct3", {12'h000, 5'd1, 3'b011, 5'd2, OPCODE_LOAD}, illegal_exp());
        add_test("branch_funct3", {7'h00, 5'd1, 5'd2, 3'b010, 5'd0, OPCODE_BRANCH}, illegal_exp());
        add_test("jalr_funct3", {12'h000, 5'd1, 3'b001, 5'd2, OPCODE_JALR}, illegal_exp());
        add_test("csr_unknown", {12'h340, 5'd1, 3'b001, 5'd2, OPCODE_SYSTEM}, illegal_exp());
        add_test("ecall", {12'h000, 5'd0, 3'b000, 5'd0, OPCODE_SYSTEM}, illegal_exp());
    endtask

    //////////////////////////////
    // Stimulus
    //////////////////////////////

    initial begin
        rst_n_i    = 1'b0;
        in_valid_i = 1'b0;
        in_instr_i = '0;
        build_table();
        repeat (4) @(negedge clk_i);
        rst_n_i = 1'b1;
        // Both stages come out of reset empty
        check_handshake("reset_in_ready", 1'b1, in_ready_o);
        check_handshake("reset_out_valid", 1'b0, out_valid_o);
        foreach (instr_q[i]) begin
            in_valid_i = 1'b1;
            in_instr_i = instr_q[i];
            do begin
                @(posedge clk_i);
            end while (!in_ready_o);   // Held until accepted
            @(negedge clk_i);
        end
        in_valid_i = 1'b0;
    end

    // Random back-pressure
    initial begin
        seed        = 78;
        out_ready_i = 1'b0;
        forever begin
            @(negedge clk_i);
            out_ready_i = ($random(seed) % 4) != 0;
        end
    end

    // Pops each output transfer in table order
    initial begin
        int idx;
        idx = 0;
        wait (rst_n_i === 1'b1);
        while (idx < exp_q.size()) begin
            @(posedge clk_i);
            if (out_valid_o && out_ready_i) begin
                if (exp_q[idx].illegal) begin
                    check_illegal(name_q[idx], exp_q[idx].illegal, out_ctrl_o.illegal);
                end else begin
                    check_ctrl(name_q[idx], exp_q[idx], out_ctrl_o);
                end
                idx++;
            end
        end
        $display("Simulation finished: PASS");
        $finish;
    end

    always @(posedge clk_i) begin
        cycles = cycles + 1;
        if (cycles > 20 * exp_q.size() + 4) begin
            stop_with_failure("Timeout, the stage stopped delivering control words");
        end
    end

endmodule

//--- list.f
design/decode_pkg.sv
design/pipe_stage.sv
design/alu_decoder.sv
design/mem_decoder.sv
design/flow_decoder.sv
design/csr_decoder.sv
design/instr_decoder.sv
design/decode_stage.sv
testbench/decode_stage_assert.sv
testbench/decode_stage_tb.sv

//--- Makefile
sim:
	verilator --binary --timing --assert -f list.f --top-module decode_stage_tb -Mdir obj_dir
	./obj_dir/Vdecode_stage_tb > sim.log 2>&1 || echo "Simulation finished: FAIL" >> sim.log
	cat sim.log
	! grep -q "Simulation finished: FAIL" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: sim clean
